// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [1:0]  tnew_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI,
        ALU_MUL
    } alu_op_t;

    // decoded control for one instruction, carried into the execute stage
    typedef struct packed {
        logic     rf_we;
        reg_idx_t dst;
        alu_op_t  alu_op;
        logic     use_imm;
        logic     imm_zero_ext;
        tnew_t    tnew;
        logic     is_eret;
        logic     unknown;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        ctrl_t ctrl;
        addr_t pc;
        word_t rs_val;
        word_t rt_val;
        word_t imm;
    } de_stage_t;

    localparam addr_t RESET_PC   = 32'h0000_3000;
    localparam addr_t HANDLER_PC = 32'h0000_4180;
    localparam word_t ERET_WORD  = 32'h4200_0018;
    localparam tnew_t MUL_TNEW   = 2'd1;

    localparam opcode_t OP_SPECIAL  = 6'h00;
    localparam opcode_t OP_ADDIU    = 6'h09;
    localparam opcode_t OP_ORI      = 6'h0d;
    localparam opcode_t OP_LUI      = 6'h0f;
    localparam opcode_t OP_SPECIAL2 = 6'h1c;

    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_MUL  = 6'h02;

endpackage

`default_nettype wire

// File: hw/de_pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module de_pipe_reg import core_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire            stall,
    input  wire            flush,
    input  wire de_stage_t d,
    output de_stage_t      e
);

    always_ff @(posedge clk) begin
        if (reset) begin
            e.valid <= 1'b0;
            e.ctrl  <= '0;
            e.pc    <= RESET_PC;
        end else if (flush) begin
            // a bubble; the pc just tracks the slot that was dropped
            e.valid <= 1'b0;
            e.ctrl  <= '0;
            e.pc    <= d.pc;
        end else if (stall) begin
            // hold the instruction and count down its remaining cycles
            if (e.ctrl.tnew != '0) begin
                e.ctrl.tnew <= e.ctrl.tnew - tnew_t'(1);
            end
        end else begin
            // d.valid already reflects acceptance on the fetch handshake
            e.valid  <= d.valid;
            e.ctrl   <= d.ctrl;
            e.pc     <= d.pc;
            e.rs_val <= d.rs_val;
            e.rt_val <= d.rt_val;
            e.imm    <= d.imm;
        end
    end

endmodule

`default_nettype wire

// File: hw/decode_execute_top.sv
`timescale 1ns/1ns
`default_nettype none

module decode_execute_top import core_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        instr_valid,
    input  wire word_t instr,
    input  wire addr_t instr_pc,
    output logic       decode_ready,
    output logic       redirect_valid,
    output addr_t      redirect_pc,
    output logic       retire_valid,
    output addr_t      retire_pc,
    output reg_idx_t   retire_dst,
    output word_t      retire_value
);

    ctrl_t     dec_ctrl;
    reg_idx_t  rs;
    reg_idx_t  rt;
    word_t     imm;
    word_t     rs_val;
    word_t     rt_val;
    de_stage_t d_stage;
    de_stage_t e_stage;
    logic      stall;
    logic      flush;
    logic      rf_we;

    assign decode_ready = !stall;

    assign d_stage.valid  = instr_valid && decode_ready;
    assign d_stage.ctrl   = dec_ctrl;
    assign d_stage.pc     = instr_pc;
    assign d_stage.rs_val = rs_val;
    assign d_stage.rt_val = rt_val;
    assign d_stage.imm    = imm;

    instr_decoder u_decoder (
        .instr (instr),
        .ctrl  (dec_ctrl),
        .rs    (rs),
        .rt    (rt),
        .imm   (imm)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs      (rs),
        .rt      (rt),
        .we      (rf_we),
        .wr_idx  (retire_dst),
        .wr_data (retire_value),
        .rs_val  (rs_val),
        .rt_val  (rt_val)
    );

    hazard_unit u_hazard (
        .e_valid        (e_stage.valid),
        .e_tnew         (e_stage.ctrl.tnew),
        .redirect_valid (redirect_valid),
        .stall          (stall),
        .flush          (flush)
    );

    de_pipe_reg u_pipe_reg (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .d     (d_stage),
        .e     (e_stage)
    );

    execute_unit u_execute (
        .clk            (clk),
        .reset          (reset),
        .e              (e_stage),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_dst     (retire_dst),
        .retire_value   (retire_value),
        .rf_we          (rf_we)
    );

endmodule

`default_nettype wire

// File: hw/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit import core_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire de_stage_t e,
    output logic           redirect_valid,
    output addr_t          redirect_pc,
    output logic           retire_valid,
    output addr_t          retire_pc,
    output reg_idx_t       retire_dst,
    output word_t          retire_value,
    output logic           rf_we
);

    word_t op_b;
    word_t alu_result;
    word_t product;
    word_t mul_lo;
    addr_t epc;
    logic  mul_first;

    assign op_b    = e.ctrl.use_imm ? e.imm : e.rt_val;
    assign product = e.rs_val * e.rt_val;

    always_comb begin
        case (e.ctrl.alu_op)
            ALU_ADD: alu_result = e.rs_val + op_b;
            ALU_SUB: alu_result = e.rs_val - op_b;
            ALU_AND: alu_result = e.rs_val & op_b;
            ALU_OR:  alu_result = e.rs_val | op_b;
            ALU_SLT: alu_result = {31'b0, $signed(e.rs_val) < $signed(op_b)};
            ALU_LUI: alu_result = {e.imm[15:0], 16'h0000};
            ALU_MUL: alu_result = mul_lo;
            default: alu_result = '0;
        endcase
    end

    // first mul cycle captures the product and the second one presents it
    assign mul_first = e.valid && (e.ctrl.alu_op == ALU_MUL) && (e.ctrl.tnew != '0);

    always_ff @(posedge clk) begin
        if (mul_first) begin
            mul_lo <= product;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (e.valid && e.ctrl.unknown) begin
            epc <= e.pc;
        end
    end

    assign redirect_valid = e.valid && (e.ctrl.unknown || e.ctrl.is_eret);
    assign redirect_pc    = e.ctrl.is_eret ? epc : HANDLER_PC;

    assign retire_valid = e.valid && (e.ctrl.tnew == '0) && !e.ctrl.unknown && !e.ctrl.is_eret;
    assign retire_pc    = e.pc;
    assign retire_dst   = e.ctrl.dst;
    assign retire_value = alu_result;
    assign rf_we        = retire_valid && e.ctrl.rf_we;

    // the slot after a redirect is always a flushed bubble
    redirect_then_bubble: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |=> !retire_valid && !redirect_valid);

endmodule

`default_nettype wire

// File: hw/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit import core_pkg::*; (
    input  wire        e_valid,
    input  wire tnew_t e_tnew,
    input  wire        redirect_valid,
    output logic       stall,
    output logic       flush
);

    // a multi-cycle op in execute blocks decode until its countdown ends
    assign stall = e_valid && (e_tnew != '0);

    // a redirect kills whatever decode holds at the next edge
    assign flush = redirect_valid;

    // only single-cycle instructions redirect, so the two never meet
    always_comb begin
        stall_flush_exclusive: assert final (!(stall && flush))
            else $error("stall and flush are high together");
    end

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder import core_pkg::*; (
    input  wire word_t instr,
    output ctrl_t      ctrl,
    output reg_idx_t   rs,
    output reg_idx_t   rt,
    output word_t      imm
);

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rd;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = ALU_ADD;
        if (instr == ERET_WORD) begin
            ctrl.is_eret = 1'b1;
        end else begin
            case (opcode)
                OP_SPECIAL: begin
                    ctrl.rf_we = 1'b1;
                    ctrl.dst   = rd;
                    case (funct)
                        FN_ADDU: ctrl.alu_op = ALU_ADD;
                        FN_SUBU: ctrl.alu_op = ALU_SUB;
                        FN_AND:  ctrl.alu_op = ALU_AND;
                        FN_OR:   ctrl.alu_op = ALU_OR;
                        FN_SLT:  ctrl.alu_op = ALU_SLT;
                        default: begin
                            ctrl.rf_we   = 1'b0;
                            ctrl.dst     = '0;
                            ctrl.unknown = 1'b1;
                        end
                    endcase
                end
                OP_SPECIAL2: begin
                    if (funct == FN_MUL) begin
                        ctrl.rf_we  = 1'b1;
                        ctrl.dst    = rd;
                        ctrl.alu_op = ALU_MUL;
                        // the product needs one extra cycle in execute
                        ctrl.tnew   = MUL_TNEW;
                    end else begin
                        ctrl.unknown = 1'b1;
                    end
                end
                OP_ADDIU: begin
                    ctrl.rf_we   = 1'b1;
                    ctrl.dst     = rt;
                    ctrl.use_imm = 1'b1;
                end
                OP_ORI: begin
                    ctrl.rf_we        = 1'b1;
                    ctrl.dst          = rt;
                    ctrl.alu_op       = ALU_OR;
                    ctrl.use_imm      = 1'b1;
                    ctrl.imm_zero_ext = 1'b1;
                end
                OP_LUI: begin
                    ctrl.rf_we        = 1'b1;
                    ctrl.dst          = rt;
                    ctrl.alu_op       = ALU_LUI;
                    ctrl.use_imm      = 1'b1;
                    ctrl.imm_zero_ext = 1'b1;
                end
                default: ctrl.unknown = 1'b1;
            endcase
        end
    end

    assign imm = ctrl.imm_zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import core_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire reg_idx_t rs,
    input  wire reg_idx_t rt,
    input  wire           we,
    input  wire reg_idx_t wr_idx,
    input  wire word_t    wr_data,
    output word_t         rs_val,
    output word_t         rt_val
);

    word_t regs [32];
    logic  wr_live;

    // register 0 is never written, so it stays at its reset value of zero
    assign wr_live = we && (wr_idx != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // the retiring result is forwarded to a read in the same cycle
    assign rs_val = (wr_live && wr_idx == rs) ? wr_data : regs[rs];
    assign rt_val = (wr_live && wr_idx == rt) ? wr_data : regs[rt];

    zero_reg_reads_zero: assert property (@(posedge clk) disable iff (reset)
        ((rs == '0) |-> (rs_val == '0)) and ((rt == '0) |-> (rt_val == '0)));

endmodule

`default_nettype wire

// File: project.f
hw/core_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/de_pipe_reg.sv
hw/execute_unit.sv
hw/decode_execute_top.sv
verification/clock_gen.sv
verification/tb_decode_execute.sv

// File: verification/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        // half of the 40 ns period
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_decode_execute.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decode_execute import core_pkg::*; ();

    typedef struct packed {
        addr_t pc;
        word_t word;
    } fetch_t;

    typedef struct packed {
        logic     redirect;
        logic     is_mul;
        addr_t    target;
        reg_idx_t dst;
        word_t    value;
    } expect_t;

    logic     clk;
    logic     reset;
    logic     instr_valid = 1'b0;
    word_t    instr = '0;
    addr_t    instr_pc = '0;
    logic     decode_ready;
    logic     redirect_valid;
    addr_t    redirect_pc;
    logic     retire_valid;
    addr_t    retire_pc;
    reg_idx_t retire_dst;
    word_t    retire_value;

    integer   seed = 33;
    word_t    prog [addr_t];
    word_t    fixup [addr_t];
    fetch_t   accept_q [$];
    word_t    arch_regs [32];
    addr_t    arch_epc;
    addr_t    fetch_pc;
    addr_t    build_pc;
    reg_idx_t last_dst;
    logic     prog_ready = 1'b0;
    logic     fetch_done = 1'b0;
    logic     started = 1'b0;
    int       n_main = 0;
    int       retire_count = 0;
    int       redirect_count = 0;
    int       mul_count = 0;
    int       stall_cycles = 0;
    int       stall_run = 0;

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    decode_execute_top dut (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .decode_ready   (decode_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_dst     (retire_dst),
        .retire_value   (retire_value)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, want));
    endtask

    function automatic word_t r_word(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
                                     input reg_idx_t rd, input funct_t fn);
        return {op, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_word(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
                                     input logic [15:0] imm16);
        return {op, rs, rt, imm16};
    endfunction

    function automatic word_t random_alu_word();
        int unsigned kind;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [15:0] imm16;
        word_t       w;
        kind  = $unsigned($random(seed)) % 8;
        rs    = reg_idx_t'($unsigned($random(seed)) % 8);
        rt    = reg_idx_t'($unsigned($random(seed)) % 8);
        rd    = reg_idx_t'($unsigned($random(seed)) % 8);
        imm16 = 16'($random(seed));
        // about half of the words read the result of the word just before them
        if ($random(seed) & 1) begin
            rs = last_dst;
        end
        case (kind)
            0: w = r_word(OP_SPECIAL, rs, rt, rd, FN_ADDU);
            1: w = r_word(OP_SPECIAL, rs, rt, rd, FN_SUBU);
            2: w = r_word(OP_SPECIAL, rs, rt, rd, FN_AND);
            3: w = r_word(OP_SPECIAL, rs, rt, rd, FN_OR);
            4: w = r_word(OP_SPECIAL, rs, rt, rd, FN_SLT);
            5: w = i_word(OP_ADDIU, rs, rd, imm16);
            6: w = i_word(OP_ORI, rs, rd, imm16);
            default: w = i_word(OP_LUI, 5'd0, rd, imm16);
        endcase
        last_dst = rd;
        return w;
    endfunction

    task automatic add_main(input word_t w);
        prog[build_pc] = w;
        build_pc += 32'd4;
        n_main++;
    endtask

    task automatic build_program();
        addr_t fault_pc;
        int    i;
        build_pc = RESET_PC;
        last_dst = '0;
        for (i = 0; i < 24; i++) begin
            add_main(random_alu_word());
        end
        // r0 takes a write and must still read as zero
        add_main(i_word(OP_ADDIU, 5'd0, 5'd0, 16'h1234));
        add_main(r_word(OP_SPECIAL, 5'd0, 5'd0, 5'd5, FN_ADDU));
        add_main(i_word(OP_ADDIU, 5'd0, 5'd1, 16'h0123));
        add_main(i_word(OP_ADDIU, 5'd0, 5'd2, 16'hfff9));
        add_main(r_word(OP_SPECIAL2, 5'd1, 5'd2, 5'd3, FN_MUL));
        add_main(r_word(OP_SPECIAL, 5'd3, 5'd1, 5'd4, FN_ADDU));
        add_main(r_word(OP_SPECIAL2, 5'd3, 5'd3, 5'd6, FN_MUL));
        add_main(r_word(OP_SPECIAL2, 5'd6, 5'd1, 5'd7, FN_MUL));
        add_main(r_word(OP_SPECIAL, 5'd7, 5'd6, 5'd8, FN_SUBU));
        // opcode 0x3f decodes to nothing and the handler patches the word once it traps
        fault_pc = build_pc;
        add_main(32'hfc00_0000);
        fixup[fault_pc] = i_word(OP_ORI, 5'd0, 5'd9, 16'hbeef);
        add_main(r_word(OP_SPECIAL, 5'd3, 5'd4, 5'd10, FN_ADDU));
        for (i = 0; i < 8; i++) begin
            add_main(random_alu_word());
        end
        prog[HANDLER_PC]          = i_word(OP_ADDIU, 5'd0, 5'd11, 16'h0055);
        prog[HANDLER_PC + 32'd4]  = i_word(OP_ORI, 5'd11, 5'd11, 16'h0a00);
        prog[HANDLER_PC + 32'd8]  = ERET_WORD;
        prog[HANDLER_PC + 32'd12] = random_alu_word();
    endtask

    // the architectural model is called once per instruction in program order
    function automatic expect_t exec_ref(input addr_t pc, input word_t w);
        expect_t  x;
        opcode_t  op;
        funct_t   fn;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        x  = '0;
        op = w[31:26];
        fn = w[5:0];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        a  = arch_regs[rs];
        b  = arch_regs[rt];
        if (w == ERET_WORD) begin
            x.redirect = 1'b1;
            x.target   = arch_epc;
        end else if (op == OP_SPECIAL && fn inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT}) begin
            x.dst = rd;
            case (fn)
                FN_ADDU: x.value = a + b;
                FN_SUBU: x.value = a - b;
                FN_AND:  x.value = a & b;
                FN_OR:   x.value = a | b;
                default: x.value = {31'b0, $signed(a) < $signed(b)};
            endcase
        end else if (op == OP_SPECIAL2 && fn == FN_MUL) begin
            x.dst    = rd;
            x.value  = a * b;
            x.is_mul = 1'b1;
        end else if (op == OP_ADDIU) begin
            x.dst   = rt;
            x.value = a + {{16{w[15]}}, w[15:0]};
        end else if (op == OP_ORI) begin
            x.dst   = rt;
            x.value = a | {16'h0000, w[15:0]};
        end else if (op == OP_LUI) begin
            x.dst   = rt;
            x.value = {w[15:0], 16'h0000};
        end else begin
            x.redirect = 1'b1;
            x.target   = HANDLER_PC;
            arch_epc   = pc;
        end
        if (!x.redirect && x.dst != '0) begin
            arch_regs[x.dst] = x.value;
        end
        return x;
    endfunction

    // the fetch model advances on acceptance and follows redirects
    always @(posedge clk) begin
        if (reset) begin
            fetch_pc = RESET_PC;
            instr_valid <= 1'b0;
        end else begin
            if (redirect_valid) begin
                // the word sitting in decode is flushed together with the redirect
                fetch_pc = redirect_pc;
            end else if (instr_valid && decode_ready) begin
                accept_q.push_back(fetch_t'{pc: instr_pc, word: instr});
                if (fixup.exists(instr_pc)) begin
                    prog[instr_pc] = fixup[instr_pc];
                    fixup.delete(instr_pc);
                end
                fetch_pc = instr_pc + 32'd4;
            end
            fetch_done = (prog.exists(fetch_pc) == 0);
            if (prog.exists(fetch_pc)) begin
                instr_valid <= 1'b1;
                instr       <= prog[fetch_pc];
                instr_pc    <= fetch_pc;
            end else begin
                instr_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        fetch_t  entry;
        expect_t want;
        if (!reset) begin
            if (!started) begin
                assert (decode_ready) else fail_run("decode_ready was low right after reset");
                started = 1'b1;
            end
            if (decode_ready) begin
                if (stall_run != 0) begin
                    assert (stall_run == 1)
                        else fail_run("decode_ready stayed low for more than one cycle");
                end
                stall_run = 0;
            end else begin
                stall_run++;
                stall_cycles++;
            end
            if (retire_valid || redirect_valid) begin
                assert (accept_q.size() != 0)
                    else fail_run("the DUT retired or redirected with no instruction accepted");
                entry = accept_q.pop_front();
                want  = exec_ref(entry.pc, entry.word);
                if (want.redirect) begin
                    assert (redirect_valid && !retire_valid)
                        else fail_run("an instruction retired where a redirect was expected");
                    assert (redirect_pc == want.target)
                        else report_mismatch("redirect_pc", redirect_pc, want.target);
                    redirect_count++;
                end else begin
                    assert (retire_valid && !redirect_valid)
                        else fail_run("a redirect was raised where a retire was expected");
                    if (retire_count == 0) begin
                        assert (retire_pc == RESET_PC)
                            else report_mismatch("first retire_pc", retire_pc, RESET_PC);
                    end
                    assert (retire_pc == entry.pc)
                        else report_mismatch("retire_pc", retire_pc, entry.pc);
                    assert (retire_dst == want.dst)
                        else report_mismatch("retire_dst", retire_dst, want.dst);
                    assert (retire_value == want.value)
                        else report_mismatch("retire_value", retire_value, want.value);
                    retire_count++;
                    if (want.is_mul) begin
                        mul_count++;
                    end
                end
            end
        end
    end

    initial begin
        wait (prog_ready);
        repeat (40 * prog.size() + 100) @(posedge clk);
        fail_run("timeout: the program did not run to its end in time");
    end

    initial begin
        int r;
        for (r = 0; r < 32; r++) begin
            arch_regs[r] = '0;
        end
        arch_epc = '0;
        build_program();
        prog_ready = 1'b1;
        wait (reset === 1'b0);
        while (!fetch_done) begin
            @(posedge clk);
        end
        // the last accepted words leave execute within a few cycles
        repeat (4) @(posedge clk);
        assert (accept_q.size() == 0)
            else fail_run("instructions were still in flight at the end of the program");
        // every main word retires once, the trapping slot through its patched word
        assert (retire_count == n_main + 2)
            else report_mismatch("retire count", retire_count, n_main + 2);
        assert (redirect_count == 2)
            else report_mismatch("redirect count", redirect_count, 2);
        assert (stall_cycles == mul_count)
            else report_mismatch("stall cycles", stall_cycles, mul_count);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
